/* rtl/math_pkg.sv */
package math_pkg;

    // Signed Q16.16 fixed point
    typedef logic signed [31:0] q16_16_t;

    typedef struct packed {
        q16_16_t x;
        q16_16_t y;
        q16_16_t z;
    } vec3_t;

    // Row-major 3x3 matrix
    typedef struct packed {
        q16_16_t r11;
        q16_16_t r12;
        q16_16_t r13;
        q16_16_t r21;
        q16_16_t r22;
        q16_16_t r23;
        q16_16_t r31;
        q16_16_t r32;
        q16_16_t r33;
    } mat3_t;

    // Full product, then drop the 16 fraction bits and wrap to one word
    function automatic q16_16_t mul_q16(input q16_16_t a, input q16_16_t b);
        logic signed [63:0] prod;
        prod = a * b;
        prod = prod >>> 16;
        return prod[31:0];
    endfunction

endpackage

/* rtl/vertex_pkg.sv */
package vertex_pkg;

    // Lanes per triangle, one per vertex
    localparam int NUM_LANES = 3;

    typedef enum logic [1:0] {
        XFORM_PASS   = 2'd0,
        XFORM_MODEL  = 2'd1,
        XFORM_CAMERA = 2'd2
    } xform_kind_t;

    typedef struct packed {
        math_pkg::vec3_t v0;
        math_pkg::vec3_t v1;
        math_pkg::vec3_t v2;
    } triangle_t;

    // Per-triangle transform descriptor
    typedef struct packed {
        xform_kind_t     kind;
        math_pkg::vec3_t pos;
        math_pkg::vec3_t scale;
        math_pkg::vec3_t rot_sin;
        math_pkg::vec3_t rot_cos;
    } transform_t;

    // Input request
    typedef struct packed {
        triangle_t  triangle;
        transform_t xform;
    } setup_req_t;

    // One vertex worth of work for a lane
    typedef struct packed {
        xform_kind_t     kind;
        math_pkg::vec3_t vertex;
        math_pkg::vec3_t pos;
        math_pkg::vec3_t scale;
        math_pkg::mat3_t matrix;
    } lane_job_t;

endpackage

/* rtl/transform_setup.sv */
module transform_setup (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire vertex_pkg::setup_req_t req,
    input  wire logic                  req_valid,
    output logic                       req_ready,

    input  wire logic                  advance,

    output vertex_pkg::lane_job_t      jobs [vertex_pkg::NUM_LANES],
    output logic                       job_valid,

    output logic                       busy
);

    typedef enum logic [1:0] {
        IDLE,
        MATRIX,
        ISSUE
    } state_t;

    state_t state;

    vertex_pkg::setup_req_t req_r;
    math_pkg::mat3_t        matrix_r;
    math_pkg::mat3_t        matrix;

    math_pkg::q16_16_t sx, cx, sy, cy, sz, cz;
    math_pkg::q16_16_t cz_sy, sz_sy;

    assign req_ready = (state == IDLE);
    assign busy      = (state != IDLE);
    assign job_valid = (state == ISSUE) && advance;

    // Z*Y*X rotation from the latched sine and cosine
    always_comb begin
        sx = req_r.xform.rot_sin.x;
        cx = req_r.xform.rot_cos.x;
        sy = req_r.xform.rot_sin.y;
        cy = req_r.xform.rot_cos.y;
        sz = req_r.xform.rot_sin.z;
        cz = req_r.xform.rot_cos.z;

        cz_sy = math_pkg::mul_q16(cz, sy);
        sz_sy = math_pkg::mul_q16(sz, sy);

        matrix.r11 = math_pkg::mul_q16(cz, cy);
        matrix.r12 = math_pkg::mul_q16(cz_sy, sx) - math_pkg::mul_q16(sz, cx);
        matrix.r13 = math_pkg::mul_q16(cz_sy, cx) + math_pkg::mul_q16(sz, sx);
        matrix.r21 = math_pkg::mul_q16(sz, cy);
        matrix.r22 = math_pkg::mul_q16(sz_sy, sx) + math_pkg::mul_q16(cz, cx);
        matrix.r23 = math_pkg::mul_q16(sz_sy, cx) - math_pkg::mul_q16(cz, sx);
        matrix.r31 = -sy;
        matrix.r32 = math_pkg::mul_q16(cy, sx);
        matrix.r33 = math_pkg::mul_q16(cy, cx);
    end

    // Jobs share everything but the vertex
    always_comb begin
        for (int i = 0; i < vertex_pkg::NUM_LANES; i++) begin
            jobs[i].kind   = req_r.xform.kind;
            jobs[i].pos    = req_r.xform.pos;
            jobs[i].scale  = req_r.xform.scale;
            jobs[i].matrix = matrix_r;
        end
        jobs[0].vertex = req_r.triangle.v0;
        jobs[1].vertex = req_r.triangle.v1;
        jobs[2].vertex = req_r.triangle.v2;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= MATRIX;
                    end
                end
                MATRIX: begin
                    state <= ISSUE;
                end
                ISSUE: begin
                    // Wait out any output stall
                    if (advance) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            req_r <= req;
        end
        if (state == MATRIX) begin
            matrix_r <= matrix;
        end
    end

endmodule

/* rtl/vertex_lane.sv */
module vertex_lane (
    input  wire logic                 clk,
    input  wire logic                 rst,

    input  wire logic                 advance,

    input  wire vertex_pkg::lane_job_t job,
    input  wire logic                 job_valid,

    output math_pkg::vec3_t           result,
    output logic                      result_valid
);

    vertex_pkg::xform_kind_t s1_kind;
    math_pkg::mat3_t         s1_matrix;
    math_pkg::vec3_t         s1_pos;
    math_pkg::vec3_t         s1_vec;
    logic                    s1_valid;

    math_pkg::vec3_t pre_vec;
    math_pkg::vec3_t rot_vec;
    math_pkg::vec3_t post_vec;

    // Stage 1 input
    always_comb begin
        case (job.kind)
            vertex_pkg::XFORM_MODEL: begin
                pre_vec.x = math_pkg::mul_q16(job.scale.x, job.vertex.x);
                pre_vec.y = math_pkg::mul_q16(job.scale.y, job.vertex.y);
                pre_vec.z = math_pkg::mul_q16(job.scale.z, job.vertex.z);
            end
            vertex_pkg::XFORM_CAMERA: begin
                pre_vec.x = job.vertex.x - job.pos.x;
                pre_vec.y = job.vertex.y - job.pos.y;
                pre_vec.z = job.vertex.z - job.pos.z;
            end
            default: begin
                pre_vec = job.vertex;
            end
        endcase
    end

    // Stage 2 input
    always_comb begin
        rot_vec.x = math_pkg::mul_q16(s1_matrix.r11, s1_vec.x)
                  + math_pkg::mul_q16(s1_matrix.r12, s1_vec.y)
                  + math_pkg::mul_q16(s1_matrix.r13, s1_vec.z);
        rot_vec.y = math_pkg::mul_q16(s1_matrix.r21, s1_vec.x)
                  + math_pkg::mul_q16(s1_matrix.r22, s1_vec.y)
                  + math_pkg::mul_q16(s1_matrix.r23, s1_vec.z);
        rot_vec.z = math_pkg::mul_q16(s1_matrix.r31, s1_vec.x)
                  + math_pkg::mul_q16(s1_matrix.r32, s1_vec.y)
                  + math_pkg::mul_q16(s1_matrix.r33, s1_vec.z);

        case (s1_kind)
            vertex_pkg::XFORM_MODEL: begin
                post_vec.x = rot_vec.x + s1_pos.x;
                post_vec.y = rot_vec.y + s1_pos.y;
                post_vec.z = rot_vec.z + s1_pos.z;
            end
            vertex_pkg::XFORM_CAMERA: begin
                post_vec = rot_vec;
            end
            default: begin
                post_vec = s1_vec;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else if (advance) begin
            s1_valid     <= job_valid;
            result_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && job_valid) begin
            s1_kind   <= job.kind;
            s1_matrix <= job.matrix;
            s1_pos    <= job.pos;
            s1_vec    <= pre_vec;
        end
        if (advance && s1_valid) begin
            result <= post_vec;
        end
    end

endmodule

/* rtl/triangle_collect.sv */
module triangle_collect (
    input  wire logic            clk,
    input  wire logic            rst,

    input  wire math_pkg::vec3_t results [vertex_pkg::NUM_LANES],
    input  wire logic            result_valid,

    output vertex_pkg::triangle_t tri_out,
    output logic                 out_valid,
    input  wire logic            out_ready,

    output logic                 advance
);

    // Stall everything while a result sits unaccepted
    assign advance = !(out_valid && !out_ready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= result_valid;
        end
    end

    // Lanes run in lockstep, so one valid covers all three
    always_ff @(posedge clk) begin
        if (advance && result_valid) begin
            tri_out.v0 <= results[0];
            tri_out.v1 <= results[1];
            tri_out.v2 <= results[2];
        end
    end

endmodule

/* rtl/transform_top.sv */
module transform_top (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire vertex_pkg::setup_req_t req,
    input  wire logic                  req_valid,
    output logic                       req_ready,

    output vertex_pkg::triangle_t      tri_out,
    output logic                       out_valid,
    input  wire logic                  out_ready,

    output logic                       busy
);

    vertex_pkg::lane_job_t jobs [vertex_pkg::NUM_LANES];
    logic                  job_valid;
    logic                  advance;
    math_pkg::vec3_t       lane_results [vertex_pkg::NUM_LANES];
    logic                  lane_valid [vertex_pkg::NUM_LANES];

    transform_setup u_setup (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .advance   (advance),
        .jobs      (jobs),
        .job_valid (job_valid),
        .busy      (busy)
    );

    for (genvar i = 0; i < vertex_pkg::NUM_LANES; i++) begin : g_lane
        vertex_lane u_lane (
            .clk          (clk),
            .rst          (rst),
            .advance      (advance),
            .job          (jobs[i]),
            .job_valid    (job_valid),
            .result       (lane_results[i]),
            .result_valid (lane_valid[i])
        );
    end

    triangle_collect u_collect (
        .clk          (clk),
        .rst          (rst),
        .results      (lane_results),
        .result_valid (lane_valid[0]),
        .tri_out      (tri_out),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .advance      (advance)
    );

endmodule

/* test/tb_transform_top.sv */
module tb_transform_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VECTORS      = 20;
    localparam int WORDS_PER_VECTOR = 31;
    localparam int TRI_WORDS        = 9;
    localparam int CYCLE_LIMIT      = NUM_VECTORS * 40 + 100;

    logic                   clk = 1'b0;
    logic                   rst;
    vertex_pkg::setup_req_t req;
    logic                   req_valid;
    logic                   req_ready;
    vertex_pkg::triangle_t  tri_out;
    logic                   out_valid;
    logic                   out_ready;
    logic                   busy;

    // Per vector the kind, triangle, pos, scale, sin, cos and expected triangle
    logic [31:0]           vec_words [NUM_VECTORS * WORDS_PER_VECTOR];
    integer                seed;
    logic [31:0]           rand_word;
    int                    out_count;
    int                    cycle_count;
    logic                  issue_pending;
    logic                  held_stall;
    vertex_pkg::triangle_t held_tri;

    transform_top UUT (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .tri_out   (tri_out),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Error at time %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic compare_triangle(input vertex_pkg::triangle_t actual,
                                    input vertex_pkg::triangle_t expected, input string what);
        for (int k = 0; k < TRI_WORDS; k++) begin
            check_value(actual[TRI_WORDS * 32 - 1 - 32 * k -: 32],
                        expected[TRI_WORDS * 32 - 1 - 32 * k -: 32],
                        $sformatf("%s word %0d", what, k));
        end
    endtask

    task automatic check_reset_state();
        check_value(req_ready, 1'b1, "req_ready in reset state");
        check_value(out_valid, 1'b0, "out_valid in reset state");
        check_value(busy, 1'b0, "busy in reset state");
    endtask

    function automatic vertex_pkg::setup_req_t build_request(input int n);
        vertex_pkg::setup_req_t r;
        int                     base;
        base = n * WORDS_PER_VECTOR;
        r.xform.kind = vertex_pkg::xform_kind_t'(vec_words[base][1:0]);
        for (int k = 0; k < TRI_WORDS; k++) begin
            r.triangle[TRI_WORDS * 32 - 1 - 32 * k -: 32] = vec_words[base + 1 + k];
        end
        r.xform.pos     = {vec_words[base + 10], vec_words[base + 11], vec_words[base + 12]};
        r.xform.scale   = {vec_words[base + 13], vec_words[base + 14], vec_words[base + 15]};
        r.xform.rot_sin = {vec_words[base + 16], vec_words[base + 17], vec_words[base + 18]};
        r.xform.rot_cos = {vec_words[base + 19], vec_words[base + 20], vec_words[base + 21]};
        return r;
    endfunction

    function automatic vertex_pkg::triangle_t expected_triangle(input int n);
        vertex_pkg::triangle_t t;
        int                    base;
        base = n * WORDS_PER_VECTOR + 22;
        for (int k = 0; k < TRI_WORDS; k++) begin
            t[TRI_WORDS * 32 - 1 - 32 * k -: 32] = vec_words[base + k];
        end
        return t;
    endfunction

    initial begin
        forever #2 clk = ~clk;
    end

    // Ready held high for the first half of the results, random after
    always @(posedge clk) begin
        #1;
        if (out_count >= NUM_VECTORS / 2) begin
            rand_word = $random(seed);
            out_ready = rand_word[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run timed out after %0d cycles before all results arrived", cycle_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    // Sampled mid-cycle, where every DUT output is settled
    always @(negedge clk) begin
        if (rst) begin
            check_reset_state();
        end else begin
            if (held_stall) begin
                check_value(out_valid, 1'b1, "out_valid dropped under back-pressure");
                compare_triangle(tri_out, held_tri, "tri_out held under back-pressure");
            end
            if (issue_pending) begin
                check_value(busy, 1'b1, "busy while a request waits for issue");
            end
            if (UUT.job_valid) begin
                issue_pending = 1'b0;
            end
            if (req_valid && req_ready) begin
                issue_pending = 1'b1;
            end
            if (out_valid && out_ready) begin
                check_value(out_count < NUM_VECTORS, 1'b1, "result beyond the last vector");
                compare_triangle(tri_out, expected_triangle(out_count),
                                 $sformatf("vector %0d", out_count));
                out_count++;
            end
            held_stall = out_valid && !out_ready;
            held_tri   = tri_out;
        end
    end

    initial begin
        rst           = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        out_ready     = 1'b1;
        seed          = 32'h5597_ead7;
        out_count     = 0;
        cycle_count   = 0;
        issue_pending = 1'b0;
        held_stall    = 1'b0;
        held_tri      = '0;
        $readmemh("test/transform_vectors.mem", vec_words);

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        #1;

        // Offer the next request as soon as the previous one transfers
        for (int n = 0; n < NUM_VECTORS; n++) begin
            req       = build_request(n);
            req_valid = 1'b1;
            @(negedge clk);
            while (!req_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        req       = '0;

        wait (out_count == NUM_VECTORS);
        repeat (20) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* test/transform_vectors.mem */
// kind, v0 v1 v2 (x y z), pos, scale, rot_sin, rot_cos (x y z), expected v0 v1 v2 (x y z)
// kind 0 pass, 1 model, 2 camera; every other word is Q16.16
0 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00010000 00010000 00010000 00020000 00008000 FFFF0000 00000000 00000000 00010000 00010000 00010000 00000000 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 00010000 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00010000 FFFE0000 00008000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 00010000 00020000 00000000 00038000 00000000 FFFE0000 00028000 00018000 FFFC0000 00048000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00000000 00000000 00000000 00010000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 00010000 FFFD0000 00020000 FFFF0000 FFFE0000 00000000 00008000 FFFC0000 FFFE0000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00030000 00020000 FFFF0000 00020000 00000000 00010000 00040000 FFFE0000 FFFF8000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00000000 00010000 00010000 00010000 00000000 FFFE0000 00010000 00030000 00000000 FFFF0000 00020000 00020000 00008000 00040000
1 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 00000000 00000000 00000000 00020000 00008000 FFFF0000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00000000 00000000 00140000 FFFD8000 FFFE8000 FFFB0000 00018000 00010000
1 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000 00000000 00000000 00000000 00008000 00008000 00008000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 FFFFFFFF 00000001 FFFE8000 00008000 FFFFC000 000091A2 FFFF6E5D 00010000
2 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00010000 00020000 00030000 00020000 00008000 FFFF0000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00000000 00000000 FFFE0000 FFFE0000 FFFF0000 FFFF8000 FFFC0000 00010000
2 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 FFFF0000 00008000 00020000 00010000 00010000 00010000 00000000 00000000 00010000 00010000 00010000 00000000 00008000 00010000 FFFE0000 00058000 000B0000 FFFF8000 FFFD8000 FFFE8000 FFFD0000
0 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000 00010000 FFFF0000 00008000 00008000 00008000 00008000 00010000 00000000 00000000 00000000 00010000 00010000 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000
1 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 000A0000 FFFB0000 00018000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 FFFF0000 000A0000 FFFB0000 00018000 00000000 00000000 00030000 000C8000 FFF80000 00008000
2 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000 00000000 00000000 00000000 00010000 00010000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000003 FFFFFFFF FFFFFFFF FFFF8000 00010000 00030000 00020000 FFFEDCBB FFFEDCBB
1 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000 00010000 00010000 00010000 00020000 00008000 FFFF0000 00000000 00000000 00010000 00010000 00010000 00000000 00010001 00010002 0000FFFD 00008000 FFFB0000 00018000 000191A3 0003468A FFFF0000
2 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 00008000 FFFF0000 00020000 00010000 00010000 00010000 FFFF0000 00000000 00000000 00000000 00010000 00010000 00008000 00010000 FFFD0000 FFFE8000 00000000 FFFF0000 00000000 00020000 00010000
1 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 00000000 00000000 FFFF0000 00008000 00008000 00008000 00010000 00000000 00000000 00000000 00010000 00010000 00000000 00000000 FFFF0000 00050000 FFFF4000 FFFC8000 FFFEC000 00008000 00008000
0 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 00020000 00020000 00020000 00010000 00010000 00010000 00000000 00010000 00000000 00010000 00000000 00010000 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000
2 00000000 00000000 00000000 000A0000 FFFB0000 00018000 FFFD8000 00030000 FFFF0000 00020000 00020000 00020000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 FFFF0000 00020000 00020000 FFFE0000 FFF80000 00070000 FFFF8000 00048000 FFFF0000 FFFD0000
1 00010000 00020000 00030000 FFFF0000 00000000 00020000 00008000 FFFE0000 00040000 FFFF0000 FFFF0000 FFFF0000 00020000 00008000 FFFF0000 00000000 00010000 00000000 00010000 00000000 00010000 FFFC0000 00000000 FFFD0000 FFFD0000 FFFF0000 00010000 FFFB0000 FFFE0000 FFFE0000
2 00000001 FFFFFFFF 00000003 FFFD0000 00010000 FFFF8000 00012345 FFFEDCBB 00020000 00010000 FFFF0000 00008000 00010000 00010000 00010000 00000000 00000000 00000000 00010000 00010000 00010000 FFFF0001 0000FFFF FFFF8003 FFFC0000 00020000 FFFF0000 00002345 FFFFDCBB 00018000

/* filelist.f */
rtl/math_pkg.sv
rtl/vertex_pkg.sv
rtl/transform_setup.sv
rtl/vertex_lane.sv
rtl/triangle_collect.sv
rtl/transform_top.sv
test/tb_transform_top.sv

/* Bender.yml */
package:
  name: transform_top

sources:
  - files:
      - rtl/math_pkg.sv
      - rtl/vertex_pkg.sv
      - rtl/transform_setup.sv
      - rtl/vertex_lane.sv
      - rtl/triangle_collect.sv
      - rtl/transform_top.sv
  - target: test
    files:
      - test/tb_transform_top.sv
